// ==== hdl/clock_pkg.sv ====
package clock_pkg;

	// ------------------------------
	// time and button bundles
	// ------------------------------
	typedef struct packed {
		logic [5:0] hour;
		logic [5:0] minute;
		logic [5:0] second;
	} hms_t;

	typedef struct packed {
		logic mode;	// clock -> setup -> alarm
		logic position;	// sec -> min -> hr
		logic incr;
		logic alarm_en;	// toggles alarm on/off
	} btn_t;

	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HR  = 2'd2
	} pos_t;

	// wrap limits, minutes share the seconds limit
	localparam logic [5:0] SEC_MAX = 6'd59;
	localparam logic [5:0] HR_MAX  = 6'd23;

	// display geometry
	localparam int NUM_DIGITS = 6;
	localparam int SEG_W      = 7;

	// segment a in the msb, g in the lsb
	localparam logic [SEG_W-1:0] SEG_TABLE [10] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001, 7'b011_0011,
		7'b101_1011, 7'b101_1111, 7'b111_0000, 7'b111_1111, 7'b111_0011
	};

	// dividers for a 50 MHz board clock
	localparam int DEF_SEC_DIV    = 50_000_000;	// 1 Hz
	localparam int DEF_SAMPLE_DIV = 500_000;	// 100 Hz button sampling
	localparam int DEF_SCAN_DIV   = 5_000;	// 10 kHz digit scan

endpackage

// ==== hdl/button_sync.sv ====
`timescale 1ns/100ps

module button_sync
	import clock_pkg::*;
#(
	parameter int SAMPLE_DIV = DEF_SAMPLE_DIV
) (
	input  btn_t i_btn,
	output btn_t o_press,
	input  logic clk,
	input  logic rst_n
);

	localparam int CNT_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

	logic [CNT_W-1:0] sample_cnt;
	logic             sample_tick;
	btn_t             sync1;
	btn_t             sync2;
	btn_t             samp0;	// previous sample
	btn_t             samp1;	// the one before

	// ------------------------------
	// metastability guard
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync1 <= '0;
			sync2 <= '0;
		end else begin
			sync1 <= i_btn;
			sync2 <= sync1;
		end
	end

	// sample tick, one cycle every SAMPLE_DIV
	assign sample_tick = (sample_cnt == CNT_W'(SAMPLE_DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sample_cnt <= '0;
		end else if (sample_tick) begin
			sample_cnt <= '0;
		end else begin
			sample_cnt <= sample_cnt + 1'b1;
		end
	end

	// pulse on low, high, high across three samples
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			samp0   <= '0;
			samp1   <= '0;
			o_press <= '0;
		end else begin
			o_press <= sample_tick ? (sync2 & samp0 & ~samp1) : '0;
			if (sample_tick) begin
				samp0 <= sync2;
				samp1 <= samp0;
			end
		end
	end

	a_press_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		(|o_press) |=> ((o_press & $past(o_press)) == '0))
		else $error("button_sync: press pulse held for two cycles");

endmodule

// ==== hdl/timekeeper.sv ====
`timescale 1ns/100ps

module timekeeper
	import clock_pkg::*;
#(
	parameter int SEC_DIV = DEF_SEC_DIV
) (
	input  btn_t i_press,
	output hms_t o_shown,
	output logic o_alarm,
	input  logic clk,
	input  logic rst_n
);

	localparam int CNT_W = (SEC_DIV > 1) ? $clog2(SEC_DIV) : 1;

	logic [CNT_W-1:0] div_cnt;
	logic             sec_tick;
	mode_t            mode;
	pos_t             pos;
	hms_t             time_r;	// running time
	hms_t             alarm_r;	// alarm setting
	logic             alarm_en;
	logic             alarm_hit;

	function automatic logic [5:0] wrap_inc(input logic [5:0] v, input logic [5:0] lim);
		return (v >= lim) ? 6'd0 : v + 6'd1;
	endfunction

	// ------------------------------
	// one second tick
	// ------------------------------
	assign sec_tick = (div_cnt == CNT_W'(SEC_DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (sec_tick) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// ------------------------------
	// mode, position, alarm enable
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode     <= MODE_CLOCK;
			pos      <= POS_SEC;
			alarm_en <= 1'b0;
		end else begin
			if (i_press.mode) begin
				case (mode)
					MODE_CLOCK: mode <= MODE_SETUP;
					MODE_SETUP: mode <= MODE_ALARM;
					default:    mode <= MODE_CLOCK;
				endcase
			end
			if (i_press.position) begin
				case (pos)
					POS_SEC: pos <= POS_MIN;
					POS_MIN: pos <= POS_HR;
					default: pos <= POS_SEC;
				endcase
			end
			if (i_press.alarm_en) begin
				alarm_en <= ~alarm_en;
			end
		end
	end

	// ------------------------------
	// running time
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			time_r <= '0;
		end else if (mode == MODE_SETUP) begin
			// frozen, incr edits one field without carry
			if (i_press.incr) begin
				case (pos)
					POS_SEC: time_r.second <= wrap_inc(time_r.second, SEC_MAX);
					POS_MIN: time_r.minute <= wrap_inc(time_r.minute, SEC_MAX);
					default: time_r.hour   <= wrap_inc(time_r.hour, HR_MAX);
				endcase
			end
		end else if (sec_tick) begin
			time_r.second <= wrap_inc(time_r.second, SEC_MAX);
			if (time_r.second == SEC_MAX) begin	// carry into minutes
				time_r.minute <= wrap_inc(time_r.minute, SEC_MAX);
				if (time_r.minute == SEC_MAX) begin
					time_r.hour <= wrap_inc(time_r.hour, HR_MAX);
				end
			end
		end
	end

	// ------------------------------
	// alarm setting
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alarm_r <= '0;
		end else if (mode == MODE_ALARM && i_press.incr) begin
			case (pos)
				POS_SEC: alarm_r.second <= wrap_inc(alarm_r.second, SEC_MAX);
				POS_MIN: alarm_r.minute <= wrap_inc(alarm_r.minute, SEC_MAX);
				default: alarm_r.hour   <= wrap_inc(alarm_r.hour, HR_MAX);
			endcase
		end
	end

	assign alarm_hit = (time_r == alarm_r);

	// latches on a match, cleared only by disabling
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else if (!alarm_en) begin
			o_alarm <= 1'b0;
		end else if (alarm_hit) begin
			o_alarm <= 1'b1;
		end
	end

	// alarm mode shows the setting, the others the time
	assign o_shown = (mode == MODE_ALARM) ? alarm_r : time_r;

	// ------------------------------
	// checks
	// ------------------------------
	a_fields_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		time_r.second <= SEC_MAX && time_r.minute <= SEC_MAX && time_r.hour <= HR_MAX &&
		alarm_r.second <= SEC_MAX && alarm_r.minute <= SEC_MAX && alarm_r.hour <= HR_MAX)
		else $error("timekeeper: field beyond wrap limit");

	a_setup_frozen: assert property (@(posedge clk) disable iff (!rst_n)
		(mode == MODE_SETUP && !i_press.incr) |=> $stable(time_r))
		else $error("timekeeper: time moved in setup mode without incr");

endmodule

// ==== hdl/digit_frame_buffer.sv ====
`timescale 1ns/100ps

module digit_frame_buffer
	import clock_pkg::*;
(
	input  hms_t             i_shown,
	input  logic             i_frame_start,
	output logic [SEG_W-1:0] o_frame [NUM_DIGITS],
	input  logic             clk,
	input  logic             rst_n
);

	logic [3:0]       digit    [NUM_DIGITS];
	logic [SEG_W-1:0] seg_next [NUM_DIGITS];

	function automatic logic [3:0] tens_of(input logic [5:0] v);
		return 4'(v / 6'd10);
	endfunction

	function automatic logic [3:0] ones_of(input logic [5:0] v);
		return 4'(v % 6'd10);
	endfunction

	// blank for anything that is not a decimal digit
	function automatic logic [SEG_W-1:0] seg_of(input logic [3:0] d);
		return (d <= 4'd9) ? SEG_TABLE[d] : '0;
	endfunction

	// ------------------------------
	// tens/ones split, digit 0 is rightmost
	// ------------------------------
	always_comb begin
		digit[0] = ones_of(i_shown.second);
		digit[1] = tens_of(i_shown.second);
		digit[2] = ones_of(i_shown.minute);
		digit[3] = tens_of(i_shown.minute);
		digit[4] = ones_of(i_shown.hour);
		digit[5] = tens_of(i_shown.hour);
	end

	always_comb begin
		for (int i = 0; i < NUM_DIGITS; i++) begin
			seg_next[i] = seg_of(digit[i]);
		end
	end

	// ------------------------------
	// frame register
	// ------------------------------
	// whole frame swaps at once so a scan never tears
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_DIGITS; i++) begin
				o_frame[i] <= SEG_TABLE[0];
			end
		end else if (i_frame_start) begin
			for (int i = 0; i < NUM_DIGITS; i++) begin
				o_frame[i] <= seg_next[i];
			end
		end
	end

endmodule

// ==== hdl/led_scan.sv ====
`timescale 1ns/100ps

module led_scan
	import clock_pkg::*;
#(
	parameter int SCAN_DIV = DEF_SCAN_DIV
) (
	input  logic [SEG_W-1:0]      i_frame [NUM_DIGITS],
	output logic                  o_frame_start,
	output logic [SEG_W-1:0]      o_seg,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	input  logic                  clk,
	input  logic                  rst_n
);

	localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
	localparam int IDX_W = $clog2(NUM_DIGITS);

	logic [CNT_W-1:0] scan_cnt;
	logic             scan_tick;
	logic [IDX_W-1:0] digit_idx;
	logic             last_digit;

	// ------------------------------
	// scan divider and digit index
	// ------------------------------
	assign scan_tick  = (scan_cnt == CNT_W'(SCAN_DIV - 1));
	assign last_digit = (digit_idx == IDX_W'(NUM_DIGITS - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_cnt  <= '0;
			digit_idx <= '0;
		end else if (scan_tick) begin
			scan_cnt  <= '0;
			digit_idx <= last_digit ? '0 : digit_idx + 1'b1;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	// new frame loads on the same edge the index returns to 0
	assign o_frame_start = scan_tick & last_digit;

	assign o_seg_enb = ~(NUM_DIGITS'(1) << digit_idx);	// active low, one cold
	assign o_seg     = i_frame[digit_idx];

	a_one_enable: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~o_seg_enb))
		else $error("led_scan: enable not one-cold: %b", o_seg_enb);

endmodule

// ==== hdl/watch_top.sv ====
`timescale 1ns/100ps

module watch_top
	import clock_pkg::*;
#(
	parameter int SEC_DIV    = DEF_SEC_DIV,
	parameter int SAMPLE_DIV = DEF_SAMPLE_DIV,
	parameter int SCAN_DIV   = DEF_SCAN_DIV
) (
	input  btn_t                  i_btn,
	output logic [SEG_W-1:0]      o_seg,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	output logic                  o_alarm,
	input  logic                  clk,
	input  logic                  rst_n
);

	btn_t             press;
	hms_t             shown;
	logic             frame_start;
	logic [SEG_W-1:0] frame [NUM_DIGITS];

	button_sync #(.SAMPLE_DIV(SAMPLE_DIV)) u_button_sync (
		.i_btn   (i_btn),
		.o_press (press),
		.clk     (clk),
		.rst_n   (rst_n)
	);

	timekeeper #(.SEC_DIV(SEC_DIV)) u_timekeeper (
		.i_press (press),
		.o_shown (shown),
		.o_alarm (o_alarm),
		.clk     (clk),
		.rst_n   (rst_n)
	);

	digit_frame_buffer u_digit_frame_buffer (
		.i_shown       (shown),
		.i_frame_start (frame_start),
		.o_frame       (frame),
		.clk           (clk),
		.rst_n         (rst_n)
	);

	led_scan #(.SCAN_DIV(SCAN_DIV)) u_led_scan (
		.i_frame       (frame),
		.o_frame_start (frame_start),
		.o_seg         (o_seg),
		.o_seg_enb     (o_seg_enb),
		.clk           (clk),
		.rst_n         (rst_n)
	);

endmodule

// ==== verification/tb_watch.sv ====
`timescale 1ns/100ps

module tb_watch
	import clock_pkg::*;
();

	localparam int SEC_DIV         = 2_000;
	localparam int SAMPLE_DIV      = 2;
	localparam int SCAN_DIV        = 4;
	localparam int MAX_PRESSES     = 600;	// upper bound over the whole sequence
	localparam int WATCHDOG_CYCLES = 200 * SEC_DIV + 400 * MAX_PRESSES;
	localparam logic [31:0] SEED   = 32'h1c21_c24f;

	localparam int BTN_MODE  = 0;
	localparam int BTN_POS   = 1;
	localparam int BTN_INCR  = 2;
	localparam int BTN_ALARM = 3;

	localparam int P_RESET = 0;
	localparam int P_CLOCK = 1;
	localparam int P_OTHER = 2;

	localparam int CHK_NONE  = 0;
	localparam int CHK_EQ    = 1;
	localparam int CHK_LATER = 2;
	localparam int CHK_CARRY = 3;

	logic                  clk;
	logic                  rst_n;
	btn_t                  btn;
	logic [SEG_W-1:0]      o_seg;
	logic [NUM_DIGITS-1:0] o_seg_enb;
	logic                  o_alarm;

	logic [31:0] lfsr;
	int          phase;
	int          check_kind;
	hms_t        exp_hms;	// expected display on CHK_EQ
	hms_t        before_t;	// reference for CHK_LATER
	hms_t        target;	// alarm time under test
	logic        alarm_on;	// expected alarm enable
	logic        en_known;	// low while an alarm_en press settles
	logic        alarm_due;

	// capture state
	int        digits [NUM_DIGITS];
	logic [5:0] got_mask;
	hms_t      cap;
	hms_t      prev_cap;
	int        cap_phase;
	int        prev_phase;
	logic      frame_new;
	logic      carry_seen;

	watch_top #(
		.SEC_DIV    (SEC_DIV),
		.SAMPLE_DIV (SAMPLE_DIV),
		.SCAN_DIV   (SCAN_DIV)
	) uut (
		.i_btn     (btn),
		.o_seg     (o_seg),
		.o_seg_enb (o_seg_enb),
		.o_alarm   (o_alarm),
		.clk       (clk),
		.rst_n     (rst_n)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic int seg_to_digit(input logic [SEG_W-1:0] s);
		case (s)
			7'b111_1110: return 0;
			7'b011_0000: return 1;
			7'b110_1101: return 2;
			7'b111_1001: return 3;
			7'b011_0011: return 4;
			7'b101_1011: return 5;
			7'b101_1111: return 6;
			7'b111_0000: return 7;
			7'b111_1111: return 8;
			7'b111_0011: return 9;
			default:     return -1;	// not a digit
		endcase
	endfunction

	function automatic int to_secs(input hms_t t);
		return int'(t.hour) * 3600 + int'(t.minute) * 60 + int'(t.second);
	endfunction

	function automatic hms_t from_secs(input int s);
		hms_t r;
		r.hour   = 6'(s / 3600);
		r.minute = 6'((s / 60) % 60);
		r.second = 6'(s % 60);
		return r;
	endfunction

	function automatic hms_t add_secs(input hms_t t, input int n);
		return from_secs((to_secs(t) + n) % 86400);
	endfunction

	function automatic int secs_ahead(input hms_t from_t, input hms_t to_t);
		return (to_secs(to_t) - to_secs(from_t) + 86400) % 86400;
	endfunction

	// one field moves, no carry
	function automatic hms_t bump_field(input hms_t t, input int p, input int n);
		hms_t r;
		r = t;
		case (p)
			0:       r.second = 6'((int'(t.second) + n) % 60);
			1:       r.minute = 6'((int'(t.minute) + n) % 60);
			default: r.hour   = 6'((int'(t.hour) + n) % 24);
		endcase
		return r;
	endfunction

	function automatic string hms_str(input hms_t t);
		return $sformatf("%02d:%02d:%02d", t.hour, t.minute, t.second);
	endfunction

	task automatic draw_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic press_button(input int which);
		@(posedge clk);
		#1;
		case (which)
			BTN_MODE: btn.mode     = 1'b1;
			BTN_POS:  btn.position = 1'b1;
			BTN_INCR: btn.incr     = 1'b1;
			default:  btn.alarm_en = 1'b1;
		endcase
		repeat (20) @(posedge clk);
		#1;
		btn = '0;
		repeat (19) @(posedge clk);	// next press adds the 20th
	endtask

	task automatic toggle_alarm();
		en_known = 1'b0;
		press_button(BTN_ALARM);
		alarm_on = ~alarm_on;
		en_known = 1'b1;
	endtask

	task automatic wait_frames(input int n);
		repeat (n) @(posedge frame_new);
	endtask

	task automatic fire_check(input int kind);
		@(posedge clk);
		#1 check_kind = kind;
		@(posedge clk);
		#1 check_kind = CHK_NONE;
	endtask

	// n incr presses on the current position, check, then step position
	task automatic edit_field(input int p, input int n, inout hms_t value);
		repeat (n) press_button(BTN_INCR);
		value = bump_field(value, p, n);
		wait_frames(2);
		exp_hms = value;
		fire_check(CHK_EQ);
		press_button(BTN_POS);
	endtask

	// ------------------------------
	// display capture
	// ------------------------------
	always @(negedge clk) begin
		int idx;
		idx = -1;
		frame_new = 1'b0;
		if (!rst_n) begin
			got_mask   = '0;
			cap        = '0;
			prev_cap   = '0;
			cap_phase  = P_OTHER;
			prev_phase = P_OTHER;
			carry_seen = 1'b0;
		end else begin
			for (int i = 0; i < NUM_DIGITS; i++) begin
				if (!o_seg_enb[i]) idx = i;
			end
			if (idx == 0) got_mask = '0;	// new scan
			if (idx >= 0) begin
				digits[idx] = seg_to_digit(o_seg);
				if (idx == NUM_DIGITS - 1 && got_mask == 6'h1f) begin
					prev_cap      = cap;
					prev_phase    = cap_phase;
					cap.second    = 6'(digits[1] * 10 + digits[0]);
					cap.minute    = 6'(digits[3] * 10 + digits[2]);
					cap.hour      = 6'(digits[5] * 10 + digits[4]);
					cap_phase     = phase;
					frame_new     = 1'b1;
					if (cap_phase == P_CLOCK && prev_phase == P_CLOCK &&
						cap.minute != prev_cap.minute) carry_seen = 1'b1;
				end
				got_mask[idx] = 1'b1;
			end
		end
	end

	// ------------------------------
	// checks
	// ------------------------------
	a_one_cold: assert property (@(posedge clk) disable iff (!rst_n) $onehot(~o_seg_enb))
		else stop_on_error($sformatf("Fail at %0t ns: o_seg_enb expected one bit low, got %b",
			$time, o_seg_enb));

	a_seg_legal: assert property (@(posedge clk) disable iff (!rst_n) seg_to_digit(o_seg) >= 0)
		else stop_on_error($sformatf("Fail at %0t ns: o_seg pattern %b is not a digit",
			$time, o_seg));

	a_reset_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(frame_new && cap_phase == P_RESET) |-> cap == '0)
		else stop_on_error($sformatf("Fail at %0t ns: display expected 00:00:00, got %s",
			$time, hms_str(cap)));

	a_clock_step: assert property (@(posedge clk) disable iff (!rst_n)
		(frame_new && cap_phase == P_CLOCK && prev_phase == P_CLOCK) |->
		(cap == prev_cap || cap == add_secs(prev_cap, 1)))
		else stop_on_error($sformatf("Fail at %0t ns: display expected %s or %s, got %s", $time,
			hms_str(prev_cap), hms_str(add_secs(prev_cap, 1)), hms_str(cap)));

	a_display_eq: assert property (@(posedge clk) disable iff (!rst_n)
		check_kind == CHK_EQ |-> cap == exp_hms)
		else stop_on_error($sformatf("Fail at %0t ns: display expected %s, got %s",
			$time, hms_str(exp_hms), hms_str(cap)));

	// forward within an hour, across midnight too
	a_time_later: assert property (@(posedge clk) disable iff (!rst_n)
		check_kind == CHK_LATER |-> secs_ahead(before_t, cap) < 3600)
		else stop_on_error($sformatf("Fail at %0t ns: display expected %s or later, got %s",
			$time, hms_str(before_t), hms_str(cap)));

	a_minute_carry: assert property (@(posedge clk) disable iff (!rst_n)
		check_kind == CHK_CARRY |-> carry_seen)
		else stop_on_error("More than 60 seconds ran in clock mode without a minute carry");

	a_alarm_off: assert property (@(posedge clk) disable iff (!rst_n)
		(en_known && !alarm_on) |-> !o_alarm)
		else stop_on_error($sformatf("Fail at %0t ns: o_alarm expected 0, got %b",
			$time, o_alarm));

	// enabled but the alarm time is still more than a second away
	a_alarm_early: assert property (@(posedge clk) disable iff (!rst_n)
		(en_known && alarm_on && !alarm_due && secs_ahead(cap, target) > 1) |-> !o_alarm)
		else stop_on_error($sformatf("Fail at %0t ns: o_alarm expected 0, got %b",
			$time, o_alarm));

	a_alarm_on: assert property (@(posedge clk) disable iff (!rst_n)
		(en_known && alarm_on && alarm_due) |-> o_alarm)
		else stop_on_error($sformatf("Fail at %0t ns: o_alarm expected 1, got %b",
			$time, o_alarm));

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		stop_on_error("Watchdog expired before the test sequence finished");
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin
		hms_t t_exp;
		hms_t a_exp;
		int   n;
		btn        = '0;
		rst_n      = 1'b0;
		lfsr       = SEED;
		phase      = P_RESET;
		check_kind = CHK_NONE;
		exp_hms    = '0;
		before_t   = '0;
		target     = '0;
		alarm_on   = 1'b0;
		en_known   = 1'b1;
		alarm_due  = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;

		wait_frames(20);	// well inside the first second
		phase = P_CLOCK;
		repeat (61 * SEC_DIV + 200) @(posedge clk);
		fire_check(CHK_CARRY);

		// setup mode, time frozen
		phase = P_OTHER;
		press_button(BTN_MODE);
		wait_frames(2);
		t_exp = cap;
		for (int p = 0; p < 3; p++) begin
			draw_bits(6, n);
			edit_field(p, n, t_exp);
		end

		// alarm mode shows the setting
		press_button(BTN_MODE);
		a_exp = '0;
		wait_frames(2);
		exp_hms = a_exp;
		fire_check(CHK_EQ);
		for (int p = 0; p < 3; p++) begin
			draw_bits(6, n);
			edit_field(p, n, a_exp);
		end
		before_t = t_exp;
		press_button(BTN_MODE);
		wait_frames(2);
		fire_check(CHK_LATER);

		// alarm a few seconds ahead
		target = add_secs(cap, 10);
		press_button(BTN_MODE);
		press_button(BTN_MODE);
		edit_field(0, (int'(target.second) - int'(a_exp.second) + 60) % 60, a_exp);
		edit_field(1, (int'(target.minute) - int'(a_exp.minute) + 60) % 60, a_exp);
		edit_field(2, (int'(target.hour) - int'(a_exp.hour) + 24) % 24, a_exp);
		press_button(BTN_MODE);
		toggle_alarm();
		wait_frames(2);
		phase = P_CLOCK;
		while (cap != target) @(posedge frame_new);
		alarm_due = 1'b1;
		repeat (3 * SEC_DIV) @(posedge clk);
		toggle_alarm();
		alarm_due = 1'b0;
		wait_frames(10);

		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== vlog.f ====
hdl/clock_pkg.sv
hdl/button_sync.sv
hdl/timekeeper.sv
hdl/digit_frame_buffer.sv
hdl/led_scan.sv
hdl/watch_top.sv
verification/tb_watch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the watch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_watch -o tb_watch \
	&& ./obj_dir/tb_watch | tee /dev/stderr | grep -q "TEST PASS" \
	|| { echo "simulation failed"; exit 1; }

echo "simulation passed"
exit 0
